/* files.f */
hw/muldiv_pkg.sv
hw/long_idiv.sv
hw/long_imul.sv
hw/hilo_regs.sv
hw/muldiv_ctrl.sv
hw/muldiv_unit.sv
tb/tb_clkgen.sv
tb/tb_muldiv.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the verdict.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_muldiv -f files.f \
  && ./obj_dir/Vtb_muldiv > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: PASS"
exit 0

/* tb/tb_muldiv.sv */
`timescale 1ns/1ps

module tb_muldiv;
  import muldiv_pkg::*;

  logic        clk;
  logic        nrst;
  logic        op_valid;
  muldiv_req_t req;
  logic        busy;
  word_t       hi;
  word_t       lo;

  integer      seed;                        // Shared $random state.
  int          errors;                      // Wrong values and late results.
  int          timeouts;                    // Waits that gave up.
  int          checks;
  word_t       exp_hi;                      // Model of HI.
  word_t       exp_lo;                      // Model of LO.

  tb_clkgen u_clkgen
  (
    .clk  (clk),
    .nrst (nrst)
  );

  muldiv_unit u_dut
  (
    .clk      (clk),
    .nrst     (nrst),
    .op_valid (op_valid),
    .req      (req),
    .busy     (busy),
    .hi       (hi),
    .lo       (lo)
  );

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Operand with a bias toward the corner values.
  function automatic word_t rand_word();
    word_t r;
    word_t v;
    r = $random(seed);
    v = $random(seed);
    case (r[2:0])
      3'd0: v = 32'h8000_0000;              // Most negative.
      3'd1: v = 32'hffff_ffff;              // Minus one, or largest unsigned.
      3'd2: v = 32'h7fff_ffff;              // Most positive.
      3'd3: v = {28'h0, v[3:0]};            // Small, zero now and then.
      3'd4: v = {{28{1'b1}}, v[3:0]};       // Small negative.
      default: ;                            // Full random word.
    endcase
    return v;
  endfunction

  // Expected HI and LO from the architectural rules.
  task automatic model_update(input muldiv_op_t op, input word_t a, input word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    dword_t             prod;
    sa = {{32{a[31]}}, a};                  // Wide enough that MIN / -1 cannot trap.
    sb = {{32{b[31]}}, b};
    case (op)
      MD_MULT:
      begin
        prod   = sa * sb;
        exp_hi = prod[63:32];
        exp_lo = prod[31:0];
      end
      MD_MULTU:
      begin
        prod   = {32'h0, a} * {32'h0, b};
        exp_hi = prod[63:32];
        exp_lo = prod[31:0];
      end
      MD_DIV, MD_DIVU:
      begin
        if ((a == '0) || (b == '0))
        begin
          exp_hi = '0;                      // Zero operand gives zero for both.
          exp_lo = '0;
        end
        else if (op == MD_DIV)
        begin
          sq     = sa / sb;                 // Truncates toward zero.
          sr     = sa % sb;                 // Sign of the dividend.
          exp_hi = sr[31:0];
          exp_lo = sq[31:0];                // Wraps at 32 bits.
        end
        else
        begin
          exp_hi = a % b;
          exp_lo = a / b;
        end
      end
      MD_MTHI: exp_hi = a;
      MD_MTLO: exp_lo = a;
      default: ;
    endcase
  endtask

  // Called 1 ns after an edge, returns 1 ns after the accepting edge.
  task automatic send_request(input muldiv_op_t op, input word_t rs, input word_t rt);
    op_valid = 1'b1;
    req.op   = op;
    req.rs   = rs;
    req.rt   = rt;
    @(posedge clk);
    #1;
    op_valid = 1'b0;
    req.op   = MD_NONE;
  endtask

  task automatic wait_idle(output int edges);
    edges = 0;
    while (busy && (edges < 100))
    begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (busy)
    begin
      timeouts++;
      $display("Timeout: busy still high %0d cycles after the request at %0t", edges, $time);
    end
  endtask

  // One arithmetic request from model to result check.
  task automatic run_arith(input muldiv_op_t op, input word_t a, input word_t b,
                           output int edges);
    model_update(op, a, b);
    send_request(op, a, b);
    wait_idle(edges);
    check_value("hi", hi, exp_hi);
    check_value("lo", lo, exp_lo);
  endtask

  initial
  begin
    int          n;
    int          edges;
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       prev_hi;
    word_t       prev_lo;
    muldiv_op_t  op;
    seed     = 99;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    exp_hi   = '0;
    exp_lo   = '0;
    op_valid = 1'b0;
    req      = '0;

    n = 0;
    while ((nrst !== 1'b1) && (n < 20))     // Reset release, bounded.
    begin
      @(posedge clk);
      n++;
    end
    if (nrst !== 1'b1)
    begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    #1;
    check_value("busy", {31'h0, busy}, 32'h0);
    check_value("hi", hi, 32'h0);
    check_value("lo", lo, 32'h0);

    // Corner products, then random ones.
    run_arith(MD_MULT, 32'h8000_0000, 32'h8000_0000, edges);
    run_arith(MD_MULT, 32'hffff_ffff, 32'hffff_ffff, edges);
    run_arith(MD_MULTU, 32'hffff_ffff, 32'hffff_ffff, edges);
    for (int i = 0; i < 200; i++)
    begin
      r  = $random(seed);
      op = r[0] ? MD_MULT : MD_MULTU;
      run_arith(op, rand_word(), rand_word(), edges);
    end

    // Overflowing and mixed-sign divides, then random ones.
    run_arith(MD_DIV, 32'h8000_0000, 32'hffff_ffff, edges);
    run_arith(MD_DIVU, 32'h8000_0000, 32'hffff_ffff, edges);
    run_arith(MD_DIV, 32'hffff_fff9, 32'h0000_0002, edges);  // -7 / 2.
    run_arith(MD_DIV, 32'h0000_0007, 32'hffff_fffe, edges);  // 7 / -2.
    for (int i = 0; i < 200; i++)
    begin
      r  = $random(seed);
      op = r[0] ? MD_DIV : MD_DIVU;
      run_arith(op, rand_word(), rand_word(), edges);
    end

    // Zero operands finish early.
    for (int i = 0; i < 20; i++)
    begin
      r  = $random(seed);
      op = r[0] ? MD_DIV : MD_DIVU;
      a  = r[1] ? '0 : rand_word();
      b  = r[1] ? rand_word() : '0;
      run_arith(op, a, b, edges);
      if (edges > 3)
      begin
        errors++;
        $display("Zero divide took %0d cycles, limit is 3, at %0t", edges, $time);
      end
    end

    // Moves touch one register only.
    for (int i = 0; i < 40; i++)
    begin
      r  = $random(seed);
      op = r[0] ? MD_MTHI : MD_MTLO;
      a  = $random(seed);
      model_update(op, a, '0);
      send_request(op, a, '0);
      check_value("busy", {31'h0, busy}, 32'h0);  // Moves never raise busy.
      check_value("hi", hi, exp_hi);
      check_value("lo", lo, exp_lo);
    end

    // A request during busy is dropped.
    for (int i = 0; i < 10; i++)
    begin
      a  = rand_word() | 32'h1;              // Nonzero, so a divide runs in full.
      b  = rand_word() | 32'h1;
      op = ((i % 2) == 0) ? MD_MULT : MD_DIVU;
      prev_hi = exp_hi;
      prev_lo = exp_lo;
      model_update(op, a, b);
      send_request(op, a, b);
      r = $random(seed);
      repeat (1 + r[3:0]) @(posedge clk);
      #1;
      check_value("busy", {31'h0, busy}, 32'h1);
      op = ((i % 3) == 0) ? MD_DIV : MD_MTHI;
      send_request(op, rand_word(), rand_word());  // Model is not updated.
      check_value("hi", hi, prev_hi);        // Nothing lands while the run is on.
      check_value("lo", lo, prev_lo);
      wait_idle(edges);
      check_value("hi", hi, exp_hi);
      check_value("lo", lo, exp_lo);
    end

    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0))
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen
(
  output logic clk,
  output logic nrst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                 // 100 ns period.
  end

  initial
  begin
    nrst = 1'b0;                            // Reset held from time zero.
    repeat (5) @(posedge clk);
    #1 nrst = 1'b1;                         // Released just after the fifth edge.
  end

endmodule

/* hw/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit
(
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    op_valid,
  input  muldiv_pkg::muldiv_req_t req,
  output logic                    busy,
  output muldiv_pkg::word_t       hi,
  output muldiv_pkg::word_t       lo
);
  import muldiv_pkg::*;

  word_t    opa;                            // Held rs operand.
  word_t    opb;                            // Held rt operand.
  logic     signd;                          // Signed mode for both units.
  logic     div_start;
  logic     mul_start;
  logic     div_ready;
  logic     mul_ready;
  dword_t   div_result;                     // Remainder and quotient.
  dword_t   mul_result;                     // 64-bit product.
  hilo_wr_t hilo_wr;                        // Write into HI/LO.

  muldiv_ctrl u_ctrl
  (
    .clk        (clk),
    .nrst       (nrst),
    .op_valid   (op_valid),
    .req        (req),
    .busy       (busy),
    .opa        (opa),
    .opb        (opb),
    .signd      (signd),
    .div_start  (div_start),
    .mul_start  (mul_start),
    .div_ready  (div_ready),
    .mul_ready  (mul_ready),
    .div_result (div_result),
    .mul_result (mul_result),
    .hilo_wr    (hilo_wr)
  );

  long_idiv u_idiv
  (
    .clk      (clk),
    .nrst     (nrst),
    .dividend (opa),
    .divider  (opb),
    .start    (div_start),
    .signd    (signd),
    .ready    (div_ready),
    .remquot  (div_result)
  );

  long_imul u_imul
  (
    .clk          (clk),
    .nrst         (nrst),
    .multiplicand (opa),
    .multiplier   (opb),
    .start        (mul_start),
    .signd        (signd),
    .ready        (mul_ready),
    .product      (mul_result)
  );

  hilo_regs u_hilo
  (
    .clk     (clk),
    .nrst    (nrst),
    .hilo_wr (hilo_wr),
    .hi      (hi),
    .lo      (lo)
  );

endmodule

/* hw/muldiv_ctrl.sv */
`timescale 1ns/1ps

module muldiv_ctrl
(
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    op_valid,
  input  muldiv_pkg::muldiv_req_t req,
  output logic                    busy,
  output muldiv_pkg::word_t       opa,
  output muldiv_pkg::word_t       opb,
  output logic                    signd,
  output logic                    div_start,
  output logic                    mul_start,
  input  logic                    div_ready,
  input  logic                    mul_ready,
  input  muldiv_pkg::dword_t      div_result,
  input  muldiv_pkg::dword_t      mul_result,
  output muldiv_pkg::hilo_wr_t    hilo_wr
);
  import muldiv_pkg::*;

  ctrl_state_t state;                       // Sequencer state.
  ctrl_state_t next_state;
  logic        accept;                      // Request taken this cycle.
  logic        is_arith;                    // Request needs an arithmetic unit.
  logic        is_div;                      // Request is a divide.
  logic        use_div;                     // Divider owns the current run.
  logic        unit_ready;                  // Ready of the unit in use.
  dword_t      unit_result;                 // Result of the unit in use.

  assign busy   = (state != CS_IDLE);
  assign accept = op_valid && !busy;        // Requests during busy are dropped.

  assign is_div   = (req.op == MD_DIV) || (req.op == MD_DIVU);
  assign is_arith = is_div || (req.op == MD_MULT) || (req.op == MD_MULTU);

  assign div_start = (state == CS_START) && use_div;
  assign mul_start = (state == CS_START) && !use_div;

  assign unit_ready  = use_div ? div_ready : mul_ready;
  assign unit_result = use_div ? div_result : mul_result;

  always_comb
  begin
    next_state = state;
    case (state)
      CS_IDLE:
        if (accept && is_arith)
          next_state = CS_START;
      CS_START:
        next_state = CS_WAIT;               // Start lasts one cycle.
      CS_WAIT:
        if (unit_ready)
          next_state = CS_IDLE;             // Result written on this edge.
      default:
        next_state = CS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state   <= CS_IDLE;
      signd   <= 1'b0;
      use_div <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if (accept && is_arith)
      begin
        signd   <= (req.op == MD_MULT) || (req.op == MD_DIV);
        use_div <= is_div;
      end
    end
  end

  // Operands stay put until the result is in HI and LO.
  always_ff @(posedge clk)
  begin
    if (accept && is_arith)
    begin
      opa <= req.rs;
      opb <= req.rt;
    end
  end

  // Unit result has priority; moves only happen while idle anyway.
  always_comb
  begin
    hilo_wr.we_hi = 1'b0;
    hilo_wr.we_lo = 1'b0;
    hilo_wr.hi    = req.rs;
    hilo_wr.lo    = req.rs;
    if ((state == CS_WAIT) && unit_ready)
    begin
      hilo_wr.we_hi = 1'b1;
      hilo_wr.we_lo = 1'b1;
      hilo_wr.hi    = unit_result[2*REG_WIDTH-1:REG_WIDTH]; // Remainder or high word.
      hilo_wr.lo    = unit_result[REG_WIDTH-1:0];           // Quotient or low word.
    end
    else if (accept)
    begin
      hilo_wr.we_hi = (req.op == MD_MTHI);  // Straight from the request.
      hilo_wr.we_lo = (req.op == MD_MTLO);
    end
  end

endmodule

/* hw/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs
(
  input  logic                 clk,
  input  logic                 nrst,
  input  muldiv_pkg::hilo_wr_t hilo_wr,
  output muldiv_pkg::word_t    hi,
  output muldiv_pkg::word_t    lo
);

  // HI, remainder or upper product word.
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
      hi <= '0;                             // Architectural reset value.
    else if (hilo_wr.we_hi)
      hi <= hilo_wr.hi;
  end

  // LO, quotient or lower product word.
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
      lo <= '0;
    else if (hilo_wr.we_lo)
      lo <= hilo_wr.lo;                     // Only on its own enable.
  end

endmodule

/* hw/long_imul.sv */
`timescale 1ns/1ps

module long_imul
(
  input  logic               clk,
  input  logic               nrst,
  input  muldiv_pkg::word_t  multiplicand,
  input  muldiv_pkg::word_t  multiplier,
  input  logic               start,
  input  logic               signd,
  output logic               ready,
  output muldiv_pkg::dword_t product
);
  import muldiv_pkg::*;

  dword_t             acc;                  // Partial product high, multiplier low.
  logic [ITER_W-1:0]  nbit;                 // Multiplier bits still to process.
  word_t              abs_mcand;            // Multiplicand magnitude for the run.
  logic [REG_WIDTH:0] sum;                  // Upper half plus addend, with carry.
  logic               neg_prod;             // Product sign fix needed.

  assign ready = (nbit == '0) && !start;    // Same rule as the divider.

  // Signs differ only in signed mode.
  assign neg_prod = signd && (multiplicand[REG_WIDTH-1] ^ multiplier[REG_WIDTH-1]);

  assign product = neg_prod ? -acc : acc;   // 64-bit two's complement fix.

  // Add the multiplicand when the current multiplier bit is set.
  assign sum = {1'b0, acc[2*REG_WIDTH-1:REG_WIDTH]} +
               (acc[0] ? {1'b0, abs_mcand} : {(REG_WIDTH+1){1'b0}});

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      acc  <= '0;
      nbit <= '0;
    end
    else if (start)
    begin
      // Low half holds the multiplier magnitude, upper half starts clear.
      acc  <= {{REG_WIDTH{1'b0}},
               (signd && multiplier[REG_WIDTH-1]) ? -multiplier : multiplier};
      nbit <= ITER_W'(REG_WIDTH);           // Full run, no early exit.
    end
    else if (nbit != '0)
    begin
      nbit <= nbit - 1'b1;
      acc  <= {sum, acc[REG_WIDTH-1:1]};    // Carry enters the top, bit 0 retires.
    end
  end

  // Multiplicand magnitude, loaded with each run.
  always_ff @(posedge clk)
  begin
    if (start)
      abs_mcand <= (signd && multiplicand[REG_WIDTH-1]) ? -multiplicand : multiplicand;
  end

endmodule

/* hw/long_idiv.sv */
`timescale 1ns/1ps

module long_idiv
(
  input  logic               clk,
  input  logic               nrst,
  input  muldiv_pkg::word_t  dividend,
  input  muldiv_pkg::word_t  divider,
  input  logic               start,
  input  logic               signd,
  output logic               ready,
  output muldiv_pkg::dword_t remquot
);
  import muldiv_pkg::*;

  dword_t             qr;                   // Partial remainder high, quotient low.
  logic [ITER_W-1:0]  nbit;                 // Quotient bits still to produce.
  word_t              abs_divider;          // Divisor magnitude, held for the run.
  logic [REG_WIDTH:0] diff;                 // Trial subtraction with borrow bit.
  logic               neg_quot;             // Quotient sign fix needed.
  logic               neg_rem;              // Remainder sign fix needed.
  word_t              rem_mag;              // Unsigned remainder.
  word_t              quot_mag;             // Unsigned quotient.

  assign ready = (nbit == '0) && !start;    // Idle and no new run pending.

  // Signs come straight from the held operands.
  assign neg_quot = signd && (dividend[REG_WIDTH-1] ^ divider[REG_WIDTH-1]);
  assign neg_rem  = signd && dividend[REG_WIDTH-1]; // Remainder follows dividend.

  assign rem_mag  = qr[2*REG_WIDTH-1:REG_WIDTH];
  assign quot_mag = qr[REG_WIDTH-1:0];

  assign remquot = {neg_rem ? -rem_mag : rem_mag,
                    neg_quot ? -quot_mag : quot_mag};

  // Shifted-in dividend bit and remainder against the divisor.
  assign diff = qr[2*REG_WIDTH-1:REG_WIDTH-1] - {1'b0, abs_divider};

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      qr   <= '0;
      nbit <= '0;
    end
    else if (start)
    begin
      if ((dividend == '0) || (divider == '0))
      begin
        qr   <= '0;                         // Zero result, no iterations.
        nbit <= '0;
      end
      else
      begin
        qr   <= {{REG_WIDTH{1'b0}}, (signd && dividend[REG_WIDTH-1]) ? -dividend : dividend};
        nbit <= ITER_W'(REG_WIDTH);         // One pass per quotient bit.
      end
    end
    else if (nbit != '0)
    begin
      nbit <= nbit - 1'b1;
      if (diff[REG_WIDTH])
        qr <= {qr[2*REG_WIDTH-2:0], 1'b0}; // Divisor too large, restore.
      else
        qr <= {diff[REG_WIDTH-1:0], qr[REG_WIDTH-2:0], 1'b1}; // Keep difference.
    end
  end

  // Divisor magnitude, loaded with each run.
  always_ff @(posedge clk)
  begin
    if (start)
      abs_divider <= (signd && divider[REG_WIDTH-1]) ? -divider : divider;
  end

endmodule

/* hw/muldiv_pkg.sv */
package muldiv_pkg;

  // Word geometry.
  localparam int REG_WIDTH = 32;            // CPU register width.
  localparam int ITER_W    = 6;             // Iteration counter width, holds 0..32.

  // A CPU register value.
  typedef logic [REG_WIDTH-1:0] word_t;

  // Full product, or remainder (high) and quotient (low).
  typedef logic [2*REG_WIDTH-1:0] dword_t;

  // Operations accepted at the unit boundary.
  typedef enum logic [2:0]
  {
    MD_NONE  = 3'd0,                        // No operation.
    MD_MULT  = 3'd1,                        // Signed multiply.
    MD_MULTU = 3'd2,                        // Unsigned multiply.
    MD_DIV   = 3'd3,                        // Signed divide.
    MD_DIVU  = 3'd4,                        // Unsigned divide.
    MD_MTHI  = 3'd5,                        // Move rs to HI.
    MD_MTLO  = 3'd6                         // Move rs to LO.
  } muldiv_op_t;

  // Request presented with op_valid.
  typedef struct packed
  {
    muldiv_op_t op;                         // Operation code.
    word_t      rs;                         // First operand, or move data.
    word_t      rt;                         // Second operand.
  } muldiv_req_t;

  // One-cycle write into the HI/LO registers.
  typedef struct packed
  {
    logic  we_hi;                           // Write enable for HI.
    logic  we_lo;                           // Write enable for LO.
    word_t hi;                              // New HI value.
    word_t lo;                              // New LO value.
  } hilo_wr_t;

  // Control sequencer states.
  typedef enum logic [1:0]
  {
    CS_IDLE  = 2'd0,                        // Waiting for a request.
    CS_START = 2'd1,                        // Start pulse to the chosen unit.
    CS_WAIT  = 2'd2                         // Waiting for the unit's ready.
  } ctrl_state_t;

endpackage
